// File: cpu_pipe.f
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/pcpu_regfile.sv
src/pcpu_decoder.sv
src/pcpu_alu.sv
src/pcpu_hazard.sv
src/pcpu_core.sv
verification/pcpu_tb.sv

// File: verification/pcpu_tb.sv
// pipelined cpu testbench

`include "cpu_consts.svh"

module pcpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          CLK_PERIOD   = 100;
    localparam int          RESET_CYCLES = 10;
    localparam int unsigned SEED         = 76998;
    localparam int          BODY_LEN     = 60;
    localparam int          NUM_PROGS    = 5;     // directed first, then random
    localparam int          MAX_CYCLES   = 2000;
    localparam int          MEM_AW       = 8;
    localparam int          MEM_WORDS    = 1 << MEM_AW;

    logic               clk;
    logic               arst_n;
    isa_pkg::reg_addr_t reg_addr;
    isa_pkg::word_t     reg_data, im_addr, im_data, dm_addr, dm_wdata, dm_rdata;
    logic               dm_we;

    isa_pkg::word_t imem [MEM_WORDS];
    isa_pkg::word_t dmem [MEM_WORDS];
    isa_pkg::word_t exp_regs [`CPU_NREGS];
    isa_pkg::word_t exp_st_addr [$];
    isa_pkg::word_t exp_st_data [$];

    int unsigned    rng;
    int             prog_len;
    int             end_pc;        // address of the final self-branch
    int             st_count;
    int             word_errs    = 0;
    int             store_errs   = 0;
    int             timeout_errs = 0;
    logic           pend_we;
    logic [MEM_AW-1:0] pend_idx;
    isa_pkg::word_t pend_data;

    assign im_data  = imem[im_addr[MEM_AW-1:0]];
    assign dm_rdata = dmem[dm_addr[MEM_AW-1:0]];

    pcpu_core dut (
        .clk(clk), .arst_n(arst_n), .reg_addr(reg_addr), .reg_data(reg_data),
        .im_addr(im_addr), .im_data(im_data), .dm_addr(dm_addr), .dm_we(dm_we),
        .dm_wdata(dm_wdata), .dm_rdata(dm_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ********************
    // stimulus helpers
    // ********************
    function automatic int unsigned next_rand();
        rng = rng * 32'd1103515245 + 32'd12345;
        return rng >> 8;   // low bits of an lcg are weak
    endfunction

    function automatic isa_pkg::word_t fill_word(input int idx);
        isa_pkg::word_t a;
        a = idx;
        return (a * 32'h9e3779b1) ^ {a[15:0], 16'h5a5a};
    endfunction

    function automatic isa_pkg::word_t rtype_word(input isa_pkg::funct_t fn, input int rs,
                                                  input int rt, input int rd, input int sh);
        isa_pkg::word_t w;
        w = '0;
        w[isa_pkg::OP_MSB:isa_pkg::OP_LSB]       = isa_pkg::OP_SPECIAL;
        w[isa_pkg::RS_MSB:isa_pkg::RS_LSB]       = rs[`CPU_RADDR_W-1:0];
        w[isa_pkg::RT_MSB:isa_pkg::RT_LSB]       = rt[`CPU_RADDR_W-1:0];
        w[isa_pkg::RD_MSB:isa_pkg::RD_LSB]       = rd[`CPU_RADDR_W-1:0];
        w[isa_pkg::SHAMT_MSB:isa_pkg::SHAMT_LSB] = sh[`CPU_SHAMT_W-1:0];
        w[isa_pkg::FUNCT_MSB:isa_pkg::FUNCT_LSB] = fn;
        return w;
    endfunction

    function automatic isa_pkg::word_t itype_word(input isa_pkg::opcode_t op, input int rs,
                                                  input int rt, input int imm);
        isa_pkg::word_t w;
        w = '0;
        w[isa_pkg::OP_MSB:isa_pkg::OP_LSB]   = op;
        w[isa_pkg::RS_MSB:isa_pkg::RS_LSB]   = rs[`CPU_RADDR_W-1:0];
        w[isa_pkg::RT_MSB:isa_pkg::RT_LSB]   = rt[`CPU_RADDR_W-1:0];
        w[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB] = imm[15:0];
        return w;
    endfunction

    task automatic emit(input isa_pkg::word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // alu chains, load-use, branches on fresh values, r0 writes
    task automatic build_directed();
        emit(itype_word(isa_pkg::OP_ADDIU, 0, 1, 5));
        emit(rtype_word(isa_pkg::FN_ADDU, 1, 1, 2, 0));    // from memory stage
        emit(rtype_word(isa_pkg::FN_SUBU, 2, 1, 3, 0));    // memory and writeback
        emit(rtype_word(isa_pkg::FN_AND, 3, 2, 4, 0));
        emit(rtype_word(isa_pkg::FN_OR, 4, 1, 5, 0));
        emit(rtype_word(isa_pkg::FN_SLTU, 1, 2, 6, 0));
        emit(rtype_word(isa_pkg::FN_SLL, 0, 2, 7, 3));
        emit(rtype_word(isa_pkg::FN_SRL, 0, 7, 8, 1));
        emit(itype_word(isa_pkg::OP_LUI, 0, 9, 16'h1234));
        emit(itype_word(isa_pkg::OP_SW, 0, 8, 4));
        emit(itype_word(isa_pkg::OP_LW, 0, 10, 4));        // reads the word just stored
        emit(rtype_word(isa_pkg::FN_ADDU, 10, 1, 11, 0));  // load-use
        emit(itype_word(isa_pkg::OP_LW, 0, 12, 4));
        emit(itype_word(isa_pkg::OP_BEQ, 12, 8, 1));       // waits on the load, taken
        emit(itype_word(isa_pkg::OP_ADDIU, 0, 13, 99));    // skipped
        emit(itype_word(isa_pkg::OP_ADDIU, 1, 14, -5));
        emit(itype_word(isa_pkg::OP_BNE, 14, 0, 1));       // falls through
        emit(itype_word(isa_pkg::OP_ADDIU, 14, 17, 3));    // only on the fall-through path
        emit(itype_word(isa_pkg::OP_ADDIU, 1, 0, 7));
        emit(rtype_word(isa_pkg::FN_ADDU, 1, 1, 0, 0));
        emit(rtype_word(isa_pkg::FN_OR, 0, 0, 15, 0));     // r0 must still be zero
        emit(itype_word(isa_pkg::OP_SW, 1, 0, 7));
        emit(itype_word(isa_pkg::OP_SW, 1, 11, 0));
        emit(itype_word(isa_pkg::OP_BNE, 1, 0, 2));        // taken, skips two
        emit(itype_word(isa_pkg::OP_SW, 0, 1, 6));
        emit(itype_word(isa_pkg::OP_ADDIU, 0, 16, 1));
        emit(itype_word(isa_pkg::OP_BEQ, 5, 5, 0));
    endtask

    task automatic build_random();
        int          k;
        int          off;
        int unsigned r;
        int          rs, rt, rd;
        end_pc = prog_len + BODY_LEN;
        for (k = 0; k < BODY_LEN; k++) begin
            r  = next_rand() % 12;
            rs = next_rand() % 10;   // few registers, many dependencies
            rt = next_rand() % 10;
            rd = next_rand() % 10;
            case (r)
                0: emit(rtype_word(isa_pkg::FN_ADDU, rs, rt, rd, 0));
                1: emit(rtype_word(isa_pkg::FN_SUBU, rs, rt, rd, 0));
                2: emit(rtype_word(isa_pkg::FN_AND, rs, rt, rd, 0));
                3: emit(rtype_word(isa_pkg::FN_OR, rs, rt, rd, 0));
                4: emit(rtype_word(isa_pkg::FN_SLTU, rs, rt, rd, 0));
                5: emit(rtype_word(isa_pkg::FN_SLL, 0, rt, rd, next_rand() % 32));
                6: emit(rtype_word(isa_pkg::FN_SRL, 0, rt, rd, next_rand() % 32));
                7: emit(itype_word(isa_pkg::OP_ADDIU, rs, rt, next_rand()));
                8: emit(itype_word(isa_pkg::OP_LUI, 0, rt, next_rand()));
                9: emit(itype_word(isa_pkg::OP_LW, rs, rt, next_rand() % 64));
                10: emit(itype_word(isa_pkg::OP_SW, rs, rt, next_rand() % 64));
                default: begin
                    off = next_rand() % 4;   // forward only, never past the end
                    if (prog_len + 1 + off > end_pc)
                        off = end_pc - prog_len - 1;
                    if (next_rand() % 2 == 0)
                        emit(itype_word(isa_pkg::OP_BEQ, rs, rt, off));
                    else
                        emit(itype_word(isa_pkg::OP_BNE, rs, rt, off));
                end
            endcase
        end
    endtask

    task automatic load_program(input int p);
        int i;
        int r;
        for (i = 0; i < MEM_WORDS; i++)
            imem[i] = '0;
        prog_len = 0;
        // every register gets a known value first
        for (r = 1; r < `CPU_NREGS; r++)
            emit(itype_word(isa_pkg::OP_ADDIU, 0, r, int'(next_rand())));
        if (p == 0)
            build_directed();
        else
            build_random();
        end_pc = prog_len;
        emit(itype_word(isa_pkg::OP_BEQ, 0, 0, -1));
    endtask

    // ********************
    // reference model
    // ********************
    function automatic void run_model();
        isa_pkg::word_t regs [`CPU_NREGS];
        isa_pkg::word_t mem [MEM_WORDS];
        isa_pkg::word_t ins, a, b, imm, addr;
        logic [5:0]     opc, fn;
        logic [`CPU_SHAMT_W-1:0] sh;
        int             pc, next_pc, steps, i, rt, rd;
        for (i = 0; i < MEM_WORDS; i++)
            mem[i] = fill_word(i);
        for (i = 0; i < `CPU_NREGS; i++)
            regs[i] = '0;
        exp_st_addr.delete();
        exp_st_data.delete();
        pc    = 0;
        steps = 0;
        while (pc != end_pc && steps < MAX_CYCLES) begin
            ins     = imem[pc];
            opc     = ins[isa_pkg::OP_MSB:isa_pkg::OP_LSB];
            fn      = ins[isa_pkg::FUNCT_MSB:isa_pkg::FUNCT_LSB];
            rt      = ins[isa_pkg::RT_MSB:isa_pkg::RT_LSB];
            rd      = ins[isa_pkg::RD_MSB:isa_pkg::RD_LSB];
            sh      = ins[isa_pkg::SHAMT_MSB:isa_pkg::SHAMT_LSB];
            a       = regs[ins[isa_pkg::RS_MSB:isa_pkg::RS_LSB]];
            b       = regs[rt];
            imm     = {{16{ins[15]}}, ins[15:0]};
            addr    = a + imm;
            next_pc = pc + 1;
            case (opc)
                isa_pkg::OP_SPECIAL: begin
                    case (fn)
                        isa_pkg::FN_ADDU: regs[rd] = a + b;
                        isa_pkg::FN_SUBU: regs[rd] = a - b;
                        isa_pkg::FN_AND:  regs[rd] = a & b;
                        isa_pkg::FN_OR:   regs[rd] = a | b;
                        isa_pkg::FN_SLTU: regs[rd] = (a < b) ? 32'd1 : 32'd0;
                        isa_pkg::FN_SLL:  regs[rd] = b << sh;
                        isa_pkg::FN_SRL:  regs[rd] = b >> sh;
                        default: ;
                    endcase
                end
                isa_pkg::OP_ADDIU: regs[rt] = addr;
                isa_pkg::OP_LUI:   regs[rt] = {ins[15:0], 16'h0000};
                isa_pkg::OP_LW:    regs[rt] = mem[addr[MEM_AW-1:0]];
                isa_pkg::OP_SW: begin
                    mem[addr[MEM_AW-1:0]] = b;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                end
                isa_pkg::OP_BEQ: if (a == b) next_pc = pc + 1 + int'($signed(ins[15:0]));
                isa_pkg::OP_BNE: if (a != b) next_pc = pc + 1 + int'($signed(ins[15:0]));
                default: ;
            endcase
            regs[0] = '0;   // hardwired zero
            pc      = next_pc;
            steps++;
        end
        for (i = 0; i < `CPU_NREGS; i++)
            exp_regs[i] = regs[i];
    endfunction

    // ********************
    // checks
    // ********************
    task automatic check_word(input string what, input isa_pkg::word_t got,
                              input isa_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            word_errs++;
        end
    endtask

    task automatic check_store(input int idx, input isa_pkg::word_t addr,
                               input isa_pkg::word_t data);
        if (idx >= exp_st_addr.size()) begin
            $display("unexpected extra store number %0d of %h to address %h", idx, data, addr);
            store_errs++;
        end else if (addr !== exp_st_addr[idx] || data !== exp_st_data[idx]) begin
            $display("FAIL %0t: store %0d wrote %h to %h, expected %h to %h", $time, idx,
                     data, addr, exp_st_data[idx], exp_st_addr[idx]);
            store_errs++;
        end
    endtask

    // stores are sampled mid-cycle and land at the next rising edge
    always @(negedge clk) begin
        if (!arst_n) begin
            st_count = 0;
            pend_we  = 1'b0;
        end else if (dm_we === 1'b1) begin
            check_store(st_count, dm_addr, dm_wdata);
            st_count++;
            pend_we   = 1'b1;
            pend_idx  = dm_addr[MEM_AW-1:0];
            pend_data = dm_wdata;
        end else begin
            pend_we = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!arst_n) begin
            for (int i = 0; i < MEM_WORDS; i++)
                dmem[i] = fill_word(i);
        end else if (pend_we) begin
            dmem[pend_idx] = pend_data;
        end
    end

    // the self-branch bounces between end_pc and end_pc+1
    task automatic wait_end(output bit ok);
        int             cyc;
        int             returns;
        isa_pkg::word_t prev;
        returns = 0;
        cyc     = 0;
        prev    = im_addr;
        while (returns < 2 && cyc < MAX_CYCLES) begin
            @(negedge clk);
            if (prev == end_pc + 1 && im_addr == end_pc)
                returns++;
            prev = im_addr;
            cyc++;
        end
        ok = (returns == 2);
    endtask

    task automatic read_registers(input int p);
        int r;
        for (r = 1; r < `CPU_NREGS; r++) begin
            @(negedge clk);
            reg_addr = r[`CPU_RADDR_W-1:0];
            #(CLK_PERIOD / 4);
            check_word($sformatf("program %0d register %0d", p, r), reg_data, exp_regs[r]);
        end
    endtask

    // ********************
    // main sequence
    // ********************
    initial begin
        int p;
        int i;
        bit ok;
        arst_n   = 1'b1;   // first real negedge comes at the first falling clock
        reg_addr = '0;
        for (i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = fill_word(i);
        end
        ok = 1'b1;
        for (p = 0; p < NUM_PROGS && ok; p++) begin
            @(negedge clk);
            arst_n   = 1'b0;
            reg_addr = '0;
            rng      = SEED + p * 32'd7919;
            load_program(p);
            run_model();
            repeat (RESET_CYCLES - 1) @(negedge clk);
            #(CLK_PERIOD / 4);
            check_word("pc in reset", im_addr, `CPU_RESET_PC);
            check_word("dm_we in reset", isa_pkg::word_t'(dm_we), '0);
            check_word("debug read of pc in reset", reg_data, `CPU_RESET_PC);
            @(negedge clk);
            arst_n = 1'b1;
            wait_end(ok);
            if (!ok) begin
                $display("timeout: program %0d never reached its final self-branch", p);
                timeout_errs++;
            end else begin
                #(CLK_PERIOD / 4);
                check_word("debug read of pc at end", reg_data, isa_pkg::word_t'(end_pc));
                read_registers(p);
                if (st_count != exp_st_addr.size()) begin
                    $display("program %0d made %0d stores but the model made %0d", p,
                             st_count, exp_st_addr.size());
                    store_errs++;
                end
            end
        end
        $display("errors: %0d register or pc, %0d store, %0d timeout",
                 word_errs, store_errs, timeout_errs);
        if (word_errs + store_errs + timeout_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: src/pcpu_core.sv
// five-stage pipelined cpu core

`include "cpu_consts.svh"

module pcpu_core (
    input  logic               clk,
    input  logic               arst_n,
    input  isa_pkg::reg_addr_t reg_addr,   // debug register select
    output isa_pkg::word_t     reg_data,
    output isa_pkg::word_t     im_addr,    // word address
    input  isa_pkg::word_t     im_data,
    output isa_pkg::word_t     dm_addr,
    output logic               dm_we,
    output isa_pkg::word_t     dm_wdata,
    input  isa_pkg::word_t     dm_rdata
);

    // fetch and decode
    isa_pkg::word_t pc_f, pc_next_f, pc_new_f;
    isa_pkg::word_t instr_d, pc_next_d;
    isa_pkg::opcode_t opcode_d;
    isa_pkg::funct_t funct_d;
    isa_pkg::reg_addr_t rs_d, rt_d, rd_d;
    logic [`CPU_SHAMT_W-1:0] shamt_d;
    logic [isa_pkg::IMM_MSB:isa_pkg::IMM_LSB] imm_d;
    isa_pkg::word_t rd1_d, rd2_d, rd_dbg;
    isa_pkg::word_t sign_imm_d, pc_branch_d, cmp_a_d, cmp_b_d;
    logic equal_d, reg_dst_d, reg_write_d, alu_src_d, mem_write_d, mem_to_reg_d;
    logic branch_d, pc_src_d;
    pipe_pkg::alu_op_t alu_op_d;
    // hazard levels
    pipe_pkg::fwd_sel_t fwd_a_e, fwd_b_e;
    logic fwd_a_d, fwd_b_d, stall_n, flush_n_d, flush_n_e;
    // execute
    logic reg_dst_e, reg_write_e, alu_src_e, mem_write_e, mem_to_reg_e;
    pipe_pkg::alu_op_t alu_op_e;
    isa_pkg::word_t rd1_e, rd2_e, imm_e, src_a_e, src_b_e, write_data_e, alu_result_e;
    isa_pkg::reg_addr_t rs_e, rt_e, rd_e, write_reg_e;
    logic [`CPU_SHAMT_W-1:0] shamt_e;
    // memory and writeback
    logic reg_write_m, mem_write_m, mem_to_reg_m, reg_write_w, mem_to_reg_w;
    isa_pkg::word_t alu_result_m, write_data_m, alu_result_w, read_data_w, result_w;
    isa_pkg::reg_addr_t write_reg_m, write_reg_w;

    function automatic isa_pkg::word_t fwd_mux(
        input pipe_pkg::fwd_sel_t sel,
        input isa_pkg::word_t     reg_val,
        input isa_pkg::word_t     mem_val,
        input isa_pkg::word_t     wb_val
    );
        case (sel)
            pipe_pkg::FWD_MEM: return mem_val;
            pipe_pkg::FWD_WB:  return wb_val;
            default:           return reg_val;
        endcase
    endfunction

    // ********************
    // fetch
    // ********************
    assign pc_next_f = pc_f + 1'b1;
    assign pc_new_f  = pc_src_d ? pc_branch_d : pc_next_f;
    assign im_addr   = pc_f;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            pc_f <= `CPU_RESET_PC;
        else if (stall_n)
            pc_f <= pc_new_f;
    end

    // instruction word of zero is a nop
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            instr_d <= '0;
        else if (!flush_n_d)
            instr_d <= '0;
        else if (stall_n)
            instr_d <= im_data;
    end

    always_ff @(posedge clk) begin
        if (stall_n)
            pc_next_d <= pc_next_f;
    end

    // ********************
    // decode
    // ********************
    assign opcode_d = isa_pkg::opcode_t'(instr_d[isa_pkg::OP_MSB:isa_pkg::OP_LSB]);
    assign funct_d  = isa_pkg::funct_t'(instr_d[isa_pkg::FUNCT_MSB:isa_pkg::FUNCT_LSB]);
    assign rs_d     = instr_d[isa_pkg::RS_MSB:isa_pkg::RS_LSB];
    assign rt_d     = instr_d[isa_pkg::RT_MSB:isa_pkg::RT_LSB];
    assign rd_d     = instr_d[isa_pkg::RD_MSB:isa_pkg::RD_LSB];
    assign shamt_d  = instr_d[isa_pkg::SHAMT_MSB:isa_pkg::SHAMT_LSB];
    assign imm_d    = instr_d[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB];

    assign sign_imm_d  = {{(`CPU_XLEN - isa_pkg::IMM_MSB - 1){imm_d[isa_pkg::IMM_MSB]}}, imm_d};
    assign pc_branch_d = pc_next_d + sign_imm_d;   // no delay slot

    // early branch compare, alu result may be forwarded from memory
    assign cmp_a_d = fwd_a_d ? alu_result_m : rd1_d;
    assign cmp_b_d = fwd_b_d ? alu_result_m : rd2_d;
    assign equal_d = (cmp_a_d == cmp_b_d);

    assign reg_data = (reg_addr != '0) ? rd_dbg : pc_f;  // address 0 shows the pc

    pcpu_regfile u_regfile (
        .clk(clk), .a1(rs_d), .a2(rt_d), .a_dbg(reg_addr),
        .rd1(rd1_d), .rd2(rd2_d), .rd_dbg(rd_dbg),
        .wa(write_reg_w), .wd(result_w), .we(reg_write_w)
    );

    pcpu_decoder u_decoder (
        .opcode(opcode_d), .funct(funct_d), .equal(equal_d),
        .reg_dst(reg_dst_d), .reg_write(reg_write_d), .alu_src(alu_src_d),
        .mem_write(mem_write_d), .mem_to_reg(mem_to_reg_d), .branch(branch_d),
        .alu_op(alu_op_d), .pc_src(pc_src_d)
    );

    // decode/execute border, control cleared on a bubble
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_dst_e    <= 1'b0;
            reg_write_e  <= 1'b0;
            alu_src_e    <= 1'b0;
            mem_write_e  <= 1'b0;
            mem_to_reg_e <= 1'b0;
            alu_op_e     <= pipe_pkg::ALU_ADD;
        end else begin
            reg_dst_e    <= reg_dst_d;
            reg_write_e  <= reg_write_d & flush_n_e;
            alu_src_e    <= alu_src_d;
            mem_write_e  <= mem_write_d & flush_n_e;
            mem_to_reg_e <= mem_to_reg_d & flush_n_e;
            alu_op_e     <= alu_op_d;
        end
    end

    always_ff @(posedge clk) begin
        rd1_e   <= rd1_d;
        rd2_e   <= rd2_d;
        imm_e   <= sign_imm_d;
        rs_e    <= rs_d;
        rt_e    <= rt_d;
        rd_e    <= rd_d;
        shamt_e <= shamt_d;
    end

    // ********************
    // execute
    // ********************
    assign src_a_e      = fwd_mux(fwd_a_e, rd1_e, alu_result_m, result_w);
    assign write_data_e = fwd_mux(fwd_b_e, rd2_e, alu_result_m, result_w);  // store data too
    assign src_b_e      = alu_src_e ? imm_e : write_data_e;
    assign write_reg_e  = reg_dst_e ? rd_e : rt_e;

    pcpu_alu u_alu (
        .src_a(src_a_e), .src_b(src_b_e), .shamt(shamt_e), .op(alu_op_e),
        .result(alu_result_e)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_write_m  <= 1'b0;
            mem_write_m  <= 1'b0;
            mem_to_reg_m <= 1'b0;
        end else begin
            reg_write_m  <= reg_write_e;
            mem_write_m  <= mem_write_e;
            mem_to_reg_m <= mem_to_reg_e;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_m <= alu_result_e;
        write_data_m <= write_data_e;
        write_reg_m  <= write_reg_e;
    end

    // ********************
    // memory and writeback
    // ********************
    assign dm_addr  = alu_result_m;
    assign dm_wdata = write_data_m;
    assign dm_we    = mem_write_m;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_write_w  <= 1'b0;
            mem_to_reg_w <= 1'b0;
        end else begin
            reg_write_w  <= reg_write_m;
            mem_to_reg_w <= mem_to_reg_m;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_w <= alu_result_m;
        read_data_w  <= dm_rdata;
        write_reg_w  <= write_reg_m;
    end

    assign result_w = mem_to_reg_w ? read_data_w : alu_result_w;

    pcpu_hazard u_hazard (
        .rs_e(rs_e), .rt_e(rt_e), .rs_d(rs_d), .rt_d(rt_d),
        .write_reg_e(write_reg_e), .write_reg_m(write_reg_m), .write_reg_w(write_reg_w),
        .reg_write_e(reg_write_e), .reg_write_m(reg_write_m), .reg_write_w(reg_write_w),
        .mem_to_reg_e(mem_to_reg_e), .mem_to_reg_m(mem_to_reg_m),
        .branch_d(branch_d), .pc_src_d(pc_src_d),
        .fwd_a_e(fwd_a_e), .fwd_b_e(fwd_b_e), .fwd_a_d(fwd_a_d), .fwd_b_d(fwd_b_d),
        .stall_n(stall_n), .flush_n_d(flush_n_d), .flush_n_e(flush_n_e)
    );

endmodule

// File: src/pcpu_hazard.sv
// pipeline hazard unit

module pcpu_hazard (
    input  isa_pkg::reg_addr_t  rs_e,
    input  isa_pkg::reg_addr_t  rt_e,
    input  isa_pkg::reg_addr_t  rs_d,
    input  isa_pkg::reg_addr_t  rt_d,
    input  isa_pkg::reg_addr_t  write_reg_e,
    input  isa_pkg::reg_addr_t  write_reg_m,
    input  isa_pkg::reg_addr_t  write_reg_w,
    input  logic                reg_write_e,
    input  logic                reg_write_m,
    input  logic                reg_write_w,
    input  logic                mem_to_reg_e,   // load in execute
    input  logic                mem_to_reg_m,   // load in memory
    input  logic                branch_d,
    input  logic                pc_src_d,
    output pipe_pkg::fwd_sel_t  fwd_a_e,
    output pipe_pkg::fwd_sel_t  fwd_b_e,
    output logic                fwd_a_d,        // comparator operand from memory
    output logic                fwd_b_d,
    output logic                stall_n,        // hold fetch and decode
    output logic                flush_n_d,
    output logic                flush_n_e
);

    logic load_stall;
    logic branch_stall;
    logic stall;

    // source reads a live destination, r0 never counts
    function automatic logic hits(input isa_pkg::reg_addr_t src, input isa_pkg::reg_addr_t dst);
        return (src != '0) && (src == dst);
    endfunction

    // memory stage wins over writeback
    function automatic pipe_pkg::fwd_sel_t exe_fwd(
        input isa_pkg::reg_addr_t src,
        input isa_pkg::reg_addr_t dst_m,
        input logic               we_m,
        input isa_pkg::reg_addr_t dst_w,
        input logic               we_w
    );
        if (we_m && hits(src, dst_m))
            return pipe_pkg::FWD_MEM;
        else if (we_w && hits(src, dst_w))
            return pipe_pkg::FWD_WB;
        else
            return pipe_pkg::FWD_NONE;
    endfunction

    // ********************
    // forwarding
    // ********************
    assign fwd_a_e = exe_fwd(rs_e, write_reg_m, reg_write_m, write_reg_w, reg_write_w);
    assign fwd_b_e = exe_fwd(rt_e, write_reg_m, reg_write_m, write_reg_w, reg_write_w);

    assign fwd_a_d = reg_write_m && hits(rs_d, write_reg_m);
    assign fwd_b_d = reg_write_m && hits(rt_d, write_reg_m);

    // ********************
    // stall and flush
    // ********************
    assign load_stall = mem_to_reg_e && (hits(rs_d, write_reg_e) || hits(rt_d, write_reg_e));

    // comparator needs a value not yet available
    assign branch_stall = branch_d && (
        (reg_write_e && (hits(rs_d, write_reg_e) || hits(rt_d, write_reg_e))) ||
        (mem_to_reg_m && (hits(rs_d, write_reg_m) || hits(rt_d, write_reg_m))));

    assign stall     = load_stall || branch_stall;
    assign stall_n   = ~stall;
    assign flush_n_e = ~stall;               // bubble into execute
    assign flush_n_d = ~(pc_src_d && !stall); // drop the fetched slot on a taken branch

endmodule

// File: src/pcpu_alu.sv
// integer alu

`include "cpu_consts.svh"

module pcpu_alu (
    input  isa_pkg::word_t          src_a,
    input  isa_pkg::word_t          src_b,
    input  logic [`CPU_SHAMT_W-1:0] shamt,
    input  pipe_pkg::alu_op_t       op,
    output isa_pkg::word_t          result
);

    localparam int HALF = `CPU_XLEN / 2;

    always_comb begin
        case (op)
            pipe_pkg::ALU_ADD:  result = src_a + src_b;
            pipe_pkg::ALU_SUB:  result = src_a - src_b;
            pipe_pkg::ALU_AND:  result = src_a & src_b;
            pipe_pkg::ALU_OR:   result = src_a | src_b;
            pipe_pkg::ALU_SLTU: begin
                result = '0;
                result[0] = (src_a < src_b);  // unsigned compare
            end
            // shifts act on operand b, as in the isa
            pipe_pkg::ALU_SLL:  result = src_b << shamt;
            pipe_pkg::ALU_SRL:  result = src_b >> shamt;
            pipe_pkg::ALU_LUI:  result = {src_b[HALF-1:0], {HALF{1'b0}}};
            default:            result = '0;
        endcase
    end

endmodule

// File: src/pcpu_decoder.sv
// instruction decoder

module pcpu_decoder (
    input  isa_pkg::opcode_t  opcode,
    input  isa_pkg::funct_t   funct,
    input  logic              equal,       // decode comparator result
    output logic              reg_dst,     // destination is rd, else rt
    output logic              reg_write,
    output logic              alu_src,     // operand b is the immediate
    output logic              mem_write,
    output logic              mem_to_reg,
    output logic              branch,
    output pipe_pkg::alu_op_t alu_op,
    output logic              pc_src       // take the branch target
);

    always_comb begin
        // no-op unless the encoding is known
        reg_dst    = 1'b0;
        reg_write  = 1'b0;
        alu_src    = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        branch     = 1'b0;
        alu_op     = pipe_pkg::ALU_ADD;
        pc_src     = 1'b0;

        case (opcode)
            isa_pkg::OP_SPECIAL: begin
                reg_dst   = 1'b1;
                reg_write = 1'b1;
                case (funct)
                    isa_pkg::FN_ADDU: alu_op = pipe_pkg::ALU_ADD;
                    isa_pkg::FN_SUBU: alu_op = pipe_pkg::ALU_SUB;
                    isa_pkg::FN_AND:  alu_op = pipe_pkg::ALU_AND;
                    isa_pkg::FN_OR:   alu_op = pipe_pkg::ALU_OR;
                    isa_pkg::FN_SLTU: alu_op = pipe_pkg::ALU_SLTU;
                    isa_pkg::FN_SLL:  alu_op = pipe_pkg::ALU_SLL;
                    isa_pkg::FN_SRL:  alu_op = pipe_pkg::ALU_SRL;
                    default: begin
                        reg_dst   = 1'b0;  // unknown funct
                        reg_write = 1'b0;
                    end
                endcase
            end
            isa_pkg::OP_ADDIU: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            isa_pkg::OP_LUI: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                alu_op    = pipe_pkg::ALU_LUI;
            end
            isa_pkg::OP_LW: begin
                reg_write  = 1'b1;
                alu_src    = 1'b1;
                mem_to_reg = 1'b1;
            end
            isa_pkg::OP_SW: begin
                alu_src   = 1'b1;    // address is base plus offset
                mem_write = 1'b1;
            end
            isa_pkg::OP_BEQ: begin
                branch = 1'b1;
                pc_src = equal;
            end
            isa_pkg::OP_BNE: begin
                branch = 1'b1;
                pc_src = ~equal;
            end
            default: ;
        endcase
    end

endmodule

// File: src/pcpu_regfile.sv
// cpu register file

`include "cpu_consts.svh"

module pcpu_regfile (
    input  logic               clk,
    input  isa_pkg::reg_addr_t a1,      // decode rs
    input  isa_pkg::reg_addr_t a2,      // decode rt
    input  isa_pkg::reg_addr_t a_dbg,   // debug read address
    output isa_pkg::word_t     rd1,
    output isa_pkg::word_t     rd2,
    output isa_pkg::word_t     rd_dbg,
    input  isa_pkg::reg_addr_t wa,
    input  isa_pkg::word_t     wd,
    input  logic               we
);

    isa_pkg::word_t regs [`CPU_NREGS];

    // read with same-cycle write bypass, r0 fixed at zero
    function automatic isa_pkg::word_t read_port(
        input isa_pkg::reg_addr_t a,
        input isa_pkg::word_t     stored,
        input logic               w_en,
        input isa_pkg::reg_addr_t w_addr,
        input isa_pkg::word_t     w_data
    );
        if (a == '0)
            return '0;
        else if (w_en && w_addr == a)
            return w_data;  // write-through
        else
            return stored;
    endfunction

    assign rd1    = read_port(a1, regs[a1], we, wa, wd);
    assign rd2    = read_port(a2, regs[a2], we, wa, wd);
    assign rd_dbg = read_port(a_dbg, regs[a_dbg], we, wa, wd);

    always_ff @(posedge clk) begin
        if (we && wa != '0)
            regs[wa] <= wd;
    end

endmodule

// File: src/pipe_pkg.sv
// pipeline control types

package pipe_pkg;

    // alu operation, set in decode and carried into execute
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_SLTU = 3'd4,  // unsigned set on less than
        ALU_SLL  = 3'd5,
        ALU_SRL  = 3'd6,
        ALU_LUI  = 3'd7   // immediate into upper half
    } alu_op_t;

    // ********************
    // operand forwarding
    // ********************

    // source of an execute operand
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,  // value read in decode
        FWD_MEM  = 2'd1,  // alu result in memory stage
        FWD_WB   = 2'd2   // writeback result
    } fwd_sel_t;

endpackage

// File: src/isa_pkg.sv
// instruction set types

`include "cpu_consts.svh"

package isa_pkg;

    typedef logic [`CPU_XLEN-1:0]    word_t;      // data or instruction word
    typedef logic [`CPU_RADDR_W-1:0] reg_addr_t;  // register number

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,  // r-type, see funct
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // funct codes for OP_SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLTU = 6'h2b
    } funct_t;

    // ********************
    // field positions
    // ********************
    localparam int OP_MSB    = 31;
    localparam int OP_LSB    = 26;
    localparam int RS_MSB    = 25;
    localparam int RS_LSB    = 21;
    localparam int RT_MSB    = 20;
    localparam int RT_LSB    = 16;
    localparam int RD_MSB    = 15;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_MSB = 10;
    localparam int SHAMT_LSB = 6;
    localparam int FUNCT_MSB = 5;
    localparam int FUNCT_LSB = 0;
    localparam int IMM_MSB   = 15;  // 16-bit immediate
    localparam int IMM_LSB   = 0;

endpackage

// File: src/cpu_consts.svh
// cpu core constants

`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath and address width
`define CPU_XLEN      32

// register file geometry
`define CPU_RADDR_W   5
`define CPU_NREGS     32

// first fetch address after reset
`define CPU_RESET_PC  0

`define CPU_SHAMT_W   5   // shift amount field

`endif
